// File: cpu_params.svh
// sizing macros for the core; IMEM_AW must equal log2(IMEM_DEPTH) and stay below 11
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define WORD_W      16   // data and instruction width
`define REG_CNT     8    // architectural registers, index fixed at 3 bits
`define IMEM_DEPTH  64   // instruction words
`define IMEM_AW     6    // instruction address bits, pc counts words

`endif

// File: isaPkg.sv
// ISA types for the kept subset only; opcodes use the course encoding, no shifts or memory ops
`default_nettype none

package isaPkg;

   typedef enum logic [4:0] {
      opHalt = 5'b00000, opNop  = 5'b00001, opJ    = 5'b00100,
      opAddi = 5'b01000, opSubi = 5'b01001, opXori = 5'b01010, opAndni = 5'b01011,
      opBeqz = 5'b01100, opBnez = 5'b01101, opBltz = 5'b01110, opBgez  = 5'b01111,
      opLbi  = 5'b11000, opAlu  = 5'b11011,
      opSeq  = 5'b11100, opSlt  = 5'b11101, opSle  = 5'b11110, opSco   = 5'b11111
   } opcodeT;

   typedef enum logic [1:0] {aluAdd, aluXor, aluAndn, aluPassB} aluOpT;

   localparam logic [1:0] bSrcReg  = 2'b00;   // register B
   localparam logic [1:0] bSrcSext = 2'b01;   // imm5 sign extended
   localparam logic [1:0] bSrcZext = 2'b10;   // imm5 zero extended
   localparam logic [1:0] bSrcZero = 2'b11;   // constant zero, branches

   localparam logic [1:0] rdHigh = 2'b00;     // dest in [10:8], LBI
   localparam logic [1:0] rdMid  = 2'b01;     // dest in [7:5], immediate group
   localparam logic [1:0] rdLow  = 2'b10;     // dest in [4:2], register group

   localparam logic [2:0] brNone       = 3'b000;
   localparam logic [2:0] brCarry      = 3'b001;  // carry out
   localparam logic [2:0] brZero       = 3'b010;
   localparam logic [2:0] brNotSign    = 3'b011;  // >= 0
   localparam logic [2:0] brSign       = 3'b100;  // < 0
   localparam logic [2:0] brNotZero    = 3'b101;
   localparam logic [2:0] brSignOrZero = 3'b110;  // <= 0

   typedef struct packed {
      logic       regWrt;      // register write in writeback
      logic       wbDataSel;   // 0 alu, 1 imm8
      logic [1:0] bSrc;
      logic [1:0] regDestSel;
      logic       invA;
      logic       invB;
      logic       cin;
      aluOpT      aluOp;
      logic [2:0] brchSig;     // condition code, see br* above
      logic       sOpSel;      // result is the condition bit
      logic       isBranch;
      logic       isJump;
      logic       isHalt;
   } ctrlT;

endpackage

`default_nettype wire

// File: corePkg.sv
// sequencer and writeback types; the writeback index is 3 bits, so at most eight registers
`include "cpu_params.svh"
`default_nettype none

package corePkg;

   typedef enum logic [2:0] {
      sIdle,
      sFetch,
      sDecode,
      sExecute,
      sWriteback,
      sHalted
   } seqStateT;

   typedef struct packed {
      logic [2:0]         idx;    // destination register
      logic [`WORD_W-1:0] data;   // value written
   } wbRecT;

endpackage

`default_nettype wire

// File: controlUnit.sv
// combinational decode of the kept subset; every other opcode only raises illegal
`include "cpu_params.svh"
`default_nettype none
`timescale 1ns/100ps

module controlUnit import isaPkg::*; (
   input  wire [`WORD_W-1:0] instr,
   output ctrlT              ctrl,
   output logic              illegal
);

   opcodeT op;

   assign op = opcodeT'(instr[15:11]);   // major opcode

   always_comb begin
      ctrl    = '0;              // nop shape, add, reg B
      illegal = 1'b0;
      case (op)
         opHalt: ctrl.isHalt = 1'b1;
         opNop: begin
         end
         opAddi, opSubi, opXori, opAndni: begin
            ctrl.regWrt     = 1'b1;
            ctrl.regDestSel = rdMid;
            ctrl.bSrc       = (op == opAddi || op == opSubi) ? bSrcSext : bSrcZext;
            ctrl.invA       = (op == opSubi);   // imm minus Rs
            ctrl.cin        = (op == opSubi);
            ctrl.invB       = (op == opAndni);  // and with ~imm
            ctrl.aluOp      = (op == opXori) ? aluXor : (op == opAndni) ? aluAndn : aluAdd;
         end
         opAlu: begin
            ctrl.regWrt     = 1'b1;
            ctrl.regDestSel = rdLow;
            ctrl.invA       = (instr[1:0] == 2'b01);  // SUB is Rt minus Rs
            ctrl.cin        = (instr[1:0] == 2'b01);
            ctrl.invB       = (instr[1:0] == 2'b11);  // ANDN
            ctrl.aluOp      = instr[1] ? (instr[0] ? aluAndn : aluXor) : aluAdd;
         end
         opSeq, opSlt, opSle, opSco: begin
            ctrl.regWrt     = 1'b1;
            ctrl.regDestSel = rdLow;
            ctrl.sOpSel     = 1'b1;
            ctrl.invB       = (op != opSco);    // compares need Rs minus Rt
            ctrl.cin        = (op != opSco);
            ctrl.brchSig    = (op == opSeq) ? brZero :
                              (op == opSlt) ? brSign :
                              (op == opSle) ? brSignOrZero : brCarry;
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.isBranch = 1'b1;
            ctrl.bSrc     = bSrcZero;           // Rs plus 0 sets the flags
            ctrl.brchSig  = (op == opBeqz) ? brZero :
                            (op == opBnez) ? brNotZero :
                            (op == opBltz) ? brSign : brNotSign;
         end
         opLbi: begin
            ctrl.regWrt     = 1'b1;
            ctrl.wbDataSel  = 1'b1;             // sign extended imm8
            ctrl.regDestSel = rdHigh;
            ctrl.aluOp      = aluPassB;
         end
         opJ: ctrl.isJump = 1'b1;
         default: illegal = 1'b1;               // cut or unknown opcode
      endcase
   end

endmodule

`default_nettype wire

// File: seqFsm.sv
// four-cycle sequencer holding the IR; run is honoured only in idle or halted
`include "cpu_params.svh"
`default_nettype none
`timescale 1ns/100ps

module seqFsm import corePkg::*, isaPkg::*; (
   input  wire                 clk,
   input  wire                 rstN,
   input  wire                 run,
   input  wire ctrlT           ctrl,
   input  wire                 illegal,
   input  wire                 condTrue,
   input  wire [`WORD_W-1:0]   imemData,   // word at pc
   input  wire [`WORD_W-1:0]   aluResult,
   output logic [`WORD_W-1:0]  instr,      // instruction register
   output logic                irLoad,
   output logic                pcClear,
   output logic                pcInc,
   output logic                pcLoad,
   output logic [10:0]         pcOffset,
   output logic                regWe,
   output logic                wbValid,
   output wbRecT               wbRec,
   output logic                halted,
   output logic                err
);

   seqStateT state;
   seqStateT nextState;
   logic     start;   // run accepted
   logic     stop;    // halt or illegal ends the program

   assign start = run && (state == sIdle || state == sHalted);
   assign stop  = ctrl.isHalt || illegal;

   always_comb begin
      nextState = state;
      case (state)
         sIdle, sHalted: begin
            if (start) nextState = sFetch;
         end
         sFetch:     nextState = sDecode;
         sDecode:    nextState = sExecute;
         sExecute:   nextState = sWriteback;
         sWriteback: nextState = stop ? sHalted : sFetch;
         default:    nextState = sIdle;
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= sIdle;
         err   <= 1'b0;
      end else begin
         state <= nextState;
         if (start) err <= 1'b0;
         else if (state == sWriteback && stop) err <= illegal;
      end
   end

   always_ff @(posedge clk) begin
      if (irLoad) instr <= imemData;   // latched at end of fetch
   end

   assign irLoad   = (state == sFetch);
   assign pcClear  = start;
   assign pcLoad   = (state == sWriteback) && (ctrl.isJump || (ctrl.isBranch && condTrue));
   assign pcInc    = (state == sWriteback) && !pcLoad;
   assign pcOffset = ctrl.isJump ? instr[10:0] : {{3{instr[7]}}, instr[7:0]};
   assign regWe    = (state == sWriteback) && ctrl.regWrt;
   assign wbValid  = regWe;             // same cycle as the rf write
   assign halted   = (state == sHalted);

   always_comb begin
      wbRec.data = aluResult;
      case (ctrl.regDestSel)
         rdMid:   wbRec.idx = instr[7:5];
         rdLow:   wbRec.idx = instr[4:2];
         default: wbRec.idx = instr[10:8];   // LBI
      endcase
   end

   // halt and illegal words decode with no register write
   noStopWrite: assert property (@(posedge clk) disable iff (!rstN)
      wbValid |-> !stop);

endmodule

`default_nettype wire

// File: pcCounter.sv
// word-addressed pc; relative targets wrap at the instruction memory depth
`include "cpu_params.svh"
`default_nettype none
`timescale 1ns/100ps

module pcCounter (
   input  wire                  clk,
   input  wire                  rstN,
   input  wire                  clear,
   input  wire                  pcInc,
   input  wire                  pcLoad,
   input  wire [10:0]           offset,   // already sign extended to 11 bits
   output logic [`IMEM_AW-1:0]  pc
);

   logic [10:0] target;

   assign target = 11'(pc) + 11'd1 + offset;   // next pc plus offset

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) pc <= '0;
      else if (clear) pc <= '0;                        // run restarts at 0
      else if (pcLoad) pc <= target[`IMEM_AW-1:0];
      else if (pcInc) pc <= pc + 1'b1;
   end

   // sequencer picks one pc source per writeback
   pcOneSrc: assert property (@(posedge clk) disable iff (!rstN) !(pcInc && pcLoad));

endmodule

`default_nettype wire

// File: regFile.sv
// register file with async reset to zero; DEPTH must not exceed eight for the 3-bit index
`include "cpu_params.svh"
`default_nettype none
`timescale 1ns/100ps

module regFile import corePkg::*; #(
   parameter int DEPTH = `REG_CNT
) (
   input  wire                 clk,
   input  wire                 rstN,
   input  wire                 we,
   input  wire wbRecT          wrRec,
   input  wire [2:0]           rdA,
   input  wire [2:0]           rdB,
   output logic [`WORD_W-1:0]  dataA,
   output logic [`WORD_W-1:0]  dataB
);

   logic [`WORD_W-1:0] regs [DEPTH];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wrRec.idx] <= wrRec.data;   // visible next cycle
      end
   end

   assign dataA = regs[rdA];   // Rs
   assign dataB = regs[rdB];   // Rt

   // writes come from the decoded IR, never from an unloaded one
   wrKnown: assert property (@(posedge clk) disable iff (!rstN) we |-> !$isunknown(wrRec.idx));

endmodule

`default_nettype wire

// File: aluUnit.sv
// single adder plus logic ops; less-than uses sign xor overflow, so signed compares are exact
`include "cpu_params.svh"
`default_nettype none
`timescale 1ns/100ps

module aluUnit import isaPkg::*; (
   input  wire ctrlT           ctrl,
   input  wire [`WORD_W-1:0]   opA,
   input  wire [`WORD_W-1:0]   instr,
   input  wire [`WORD_W-1:0]   regB,
   output logic [`WORD_W-1:0]  result,
   output logic                condTrue
);

   logic [`WORD_W-1:0] bSel;
   logic [`WORD_W-1:0] aIn;
   logic [`WORD_W-1:0] bIn;
   logic [`WORD_W:0]   sum;      // carry on top
   logic               zeroF;
   logic               signF;
   logic               carryF;
   logic               ovf;

   always_comb begin
      case (ctrl.bSrc)
         bSrcReg:  bSel = regB;
         bSrcSext: bSel = {{(`WORD_W-5){instr[4]}}, instr[4:0]};
         bSrcZext: bSel = {{(`WORD_W-5){1'b0}}, instr[4:0]};
         default:  bSel = '0;
      endcase
   end

   assign aIn    = ctrl.invA ? ~opA : opA;
   assign bIn    = ctrl.invB ? ~bSel : bSel;
   assign sum    = {1'b0, aIn} + {1'b0, bIn} + {{`WORD_W{1'b0}}, ctrl.cin};
   assign zeroF  = (sum[`WORD_W-1:0] == '0);
   assign ovf    = (aIn[`WORD_W-1] == bIn[`WORD_W-1]) && (sum[`WORD_W-1] != aIn[`WORD_W-1]);
   assign signF  = sum[`WORD_W-1] ^ ovf;   // plain sign bit when B is 0
   assign carryF = sum[`WORD_W];

   always_comb begin
      case (ctrl.brchSig)
         brCarry:      condTrue = carryF;
         brZero:       condTrue = zeroF;
         brNotSign:    condTrue = !signF;
         brSign:       condTrue = signF;
         brNotZero:    condTrue = !zeroF;
         brSignOrZero: condTrue = signF || zeroF;
         default:      condTrue = 1'b0;
      endcase
   end

   always_comb begin
      case (ctrl.aluOp)
         aluAdd:  result = sum[`WORD_W-1:0];
         aluXor:  result = aIn ^ bIn;
         aluAndn: result = aIn & bIn;      // invB supplies the not
         default: result = bIn;            // pass B
      endcase
      if (ctrl.sOpSel)
         result = {{(`WORD_W-1){1'b0}}, condTrue};            // set ops give 0 or 1
      if (ctrl.wbDataSel)
         result = {{(`WORD_W-8){instr[7]}}, instr[7:0]};      // LBI
   end

endmodule

`default_nettype wire

// File: instrMem.sv
// instruction store with async read; loading while the core runs is not guarded here
`include "cpu_params.svh"
`default_nettype none
`timescale 1ns/100ps

module instrMem #(
   parameter int DEPTH = `IMEM_DEPTH
) (
   input  wire                      clk,
   input  wire                      we,
   input  wire [$clog2(DEPTH)-1:0]  wrAddr,
   input  wire [`WORD_W-1:0]        wrData,
   input  wire [$clog2(DEPTH)-1:0]  rdAddr,
   output logic [`WORD_W-1:0]       rdData
);

   logic [`WORD_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (we) mem[wrAddr] <= wrData;   // program load
   end

   assign rdData = mem[rdAddr];   // word at pc

endmodule

`default_nettype wire

// File: cpuTop.sv
// core top; progWe is only safe while idle or halted, and wbValid has no back-pressure
`include "cpu_params.svh"
`default_nettype none
`timescale 1ns/100ps

module cpuTop import isaPkg::*, corePkg::*; (
   input  wire                   clk,
   input  wire                   rstN,
   input  wire                   progWe,
   input  wire [`IMEM_AW-1:0]    progAddr,
   input  wire [`WORD_W-1:0]     progData,
   input  wire                   run,
   output logic                  wbValid,
   output wbRecT                 wbRec,
   output logic                  halted,
   output logic                  err
);

   ctrlT                ctrl;
   logic                illegal;
   logic                condTrue;
   logic [`WORD_W-1:0]  instr;       // IR from the sequencer
   logic [`WORD_W-1:0]  imemData;
   logic [`WORD_W-1:0]  aluResult;
   logic [`WORD_W-1:0]  dataA;
   logic [`WORD_W-1:0]  dataB;
   logic [`IMEM_AW-1:0] pc;
   logic [10:0]         pcOffset;
   logic                pcClear;
   logic                pcInc;
   logic                pcLoad;
   logic                regWe;

   instrMem #(.DEPTH(`IMEM_DEPTH)) imem0 (
      .clk(clk), .we(progWe), .wrAddr(progAddr), .wrData(progData),
      .rdAddr(pc), .rdData(imemData)
   );

   seqFsm seq0 (
      .clk(clk), .rstN(rstN), .run(run), .ctrl(ctrl), .illegal(illegal),
      .condTrue(condTrue), .imemData(imemData), .aluResult(aluResult),
      .instr(instr),
      .irLoad(),                  // IR is loaded inside the sequencer
      .pcClear(pcClear), .pcInc(pcInc), .pcLoad(pcLoad), .pcOffset(pcOffset),
      .regWe(regWe), .wbValid(wbValid), .wbRec(wbRec), .halted(halted), .err(err)
   );

   controlUnit dec0 (
      .instr(instr), .ctrl(ctrl), .illegal(illegal)
   );

   pcCounter pc0 (
      .clk(clk), .rstN(rstN), .clear(pcClear), .pcInc(pcInc), .pcLoad(pcLoad),
      .offset(pcOffset), .pc(pc)
   );

   regFile #(.DEPTH(`REG_CNT)) rf0 (
      .clk(clk), .rstN(rstN), .we(regWe), .wrRec(wbRec),
      .rdA(instr[10:8]), .rdB(instr[7:5]),     // Rs and Rt fields
      .dataA(dataA), .dataB(dataB)
   );

   aluUnit alu0 (
      .ctrl(ctrl), .opA(dataA), .instr(instr), .regB(dataB),
      .result(aluResult), .condTrue(condTrue)
   );

endmodule

`default_nettype wire

// File: tbCpu.sv
// random-program testbench; offsets are forward only and registers keep their values between runs
`include "cpu_params.svh"
`default_nettype none
`timescale 1ns/100ps

module tbCpu import corePkg::*;;

   localparam int NUM_TESTS = 12;
   localparam int PER_TEST  = `IMEM_DEPTH + 4 * `IMEM_DEPTH + 50;   // load, run, margin
   localparam int LIMIT     = NUM_TESTS * PER_TEST;

   typedef struct packed {
      wbRecT       rec;
      logic [31:0] at;   // cycles after run
   } expWbT;

   logic                 clk;
   logic                 rstN;
   logic                 progWe;
   logic [`IMEM_AW-1:0]  progAddr;
   logic [`WORD_W-1:0]   progData;
   logic                 run;
   logic                 wbValid;
   wbRecT                wbRec;
   logic                 halted;
   logic                 err;

   logic [15:0] lfsr = 16'd71;             // seed
   logic [15:0] prog [`IMEM_DEPTH];        // program image
   logic [15:0] mRegs [`REG_CNT];          // model registers
   logic [4:0]  badOps [15] = '{5'b00010, 5'b00011, 5'b00101, 5'b00110, 5'b00111,
                                5'b10000, 5'b10001, 5'b10010, 5'b10011, 5'b10100,
                                5'b10101, 5'b10110, 5'b10111, 5'b11001, 5'b11010};
   expWbT       expQ [$];
   int          cycle = 0;
   int          runCycle = 0;
   int          errCount = 0;

   cpuTop dut0 (
      .clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .run(run), .wbValid(wbValid), .wbRec(wbRec), .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns
   end

   always @(posedge clk) cycle <= cycle + 1;

   function automatic logic [15:0] galoisNext(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
   endfunction

   task automatic takeBits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], lfsr[0]};   // one step per bit
         lfsr = galoisNext(lfsr);
      end
   endtask

   task automatic checkValue(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         errCount++;
         $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic randomInstr(output logic [15:0] w);
      logic [15:0] kind;
      logic [15:0] a;
      logic [15:0] b;
      takeBits(4, kind);
      takeBits(11, a);   // register and imm fields
      takeBits(3, b);    // small forward offset
      case (kind[3:0])
         4'd0, 4'd1, 4'd2, 4'd3: w = {3'b010, kind[1:0], a[10:0]};      // imm group
         4'd4, 4'd5:             w = {5'b11000, a[10:0]};               // LBI
         4'd6, 4'd7, 4'd8, 4'd15: w = {5'b11011, a[10:0]};           // reg ALU with func in [1:0]
         4'd9, 4'd10:            w = {3'b111, b[1:0], a[10:0]};         // SEQ..SCO
         4'd11, 4'd12:           w = {3'b011, a[1:0], a[10:8], 5'b0, b[2:0]};
         4'd13:                  w = {5'b00100, 8'b0, b[2:0]};          // J forward
         default:                w = {5'b00001, a[10:0]};               // NOP
      endcase
   endtask

   task automatic buildProgram(input logic withIllegal);
      logic [15:0] r;
      logic [15:0] w;
      int          len;
      int          bad;
      takeBits(5, r);
      len = int'(r[4:0]) + 1;   // 1..32 instructions
      for (int a = 0; a < `IMEM_DEPTH; a++) begin
         if (a < len) randomInstr(w);
         else w = 16'h0000;     // HALT fill
         prog[a] = w;
      end
      if (withIllegal) begin
         takeBits(5, r);
         bad = int'(r[4:0]) % len;
         takeBits(4, r);
         w[15:11] = badOps[int'(r[3:0]) % 15];
         takeBits(11, r);
         prog[bad] = {w[15:11], r[10:0]};
      end
   endtask

   task automatic runModel(output int haltAt, output logic expErr, output int nWr);
      logic [5:0]  pc;
      logic [15:0] w;
      logic [15:0] rs;
      logic [15:0] rt;
      logic [15:0] val;
      logic [16:0] wide;
      logic [10:0] off;
      logic [2:0]  rd;
      logic        wr;
      logic        take;
      logic        done;
      expWbT       e;
      pc = '0;
      done = 1'b0;
      expErr = 1'b0;
      nWr = 0;
      haltAt = 0;
      for (int step = 0; step < `IMEM_DEPTH && !done; step++) begin
         w = prog[pc];
         rs = mRegs[w[10:8]];
         rt = mRegs[w[7:5]];
         off = {{3{w[7]}}, w[7:0]};   // branch imm8
         wr = 1'b1;
         take = 1'b0;
         rd = w[7:5];
         val = '0;
         case (w[15:11])
            5'b01000: val = rs + {{11{w[4]}}, w[4:0]};
            5'b01001: val = {{11{w[4]}}, w[4:0]} - rs;   // imm minus Rs
            5'b01010: val = rs ^ {11'b0, w[4:0]};
            5'b01011: val = rs & ~{11'b0, w[4:0]};
            5'b11000: begin
               rd = w[10:8];
               val = {{8{w[7]}}, w[7:0]};
            end
            5'b11011: begin
               rd = w[4:2];
               case (w[1:0])
                  2'b00:   val = rs + rt;
                  2'b01:   val = rt - rs;
                  2'b10:   val = rs ^ rt;
                  default: val = rs & ~rt;
               endcase
            end
            5'b11100, 5'b11101, 5'b11110, 5'b11111: begin
               rd = w[4:2];
               wide = {1'b0, rs} + {1'b0, rt};
               case (w[12:11])
                  2'b00:   val = {15'b0, rs == rt};
                  2'b01:   val = {15'b0, $signed(rs) < $signed(rt)};
                  2'b10:   val = {15'b0, $signed(rs) <= $signed(rt)};
                  default: val = {15'b0, wide[16]};   // carry out
               endcase
            end
            5'b01100, 5'b01101, 5'b01110, 5'b01111: begin
               wr = 1'b0;
               case (w[12:11])
                  2'b00:   take = (rs == 16'd0);
                  2'b01:   take = (rs != 16'd0);
                  2'b10:   take = rs[15];
                  default: take = !rs[15];
               endcase
            end
            5'b00100: begin
               wr = 1'b0;
               take = 1'b1;
               off = w[10:0];   // imm11
            end
            5'b00001: wr = 1'b0;
            5'b00000: begin
               wr = 1'b0;
               done = 1'b1;
            end
            default: begin
               wr = 1'b0;
               done = 1'b1;
               expErr = 1'b1;   // not in the subset
            end
         endcase
         if (wr) begin
            mRegs[rd] = val;
            e.rec.idx = rd;
            e.rec.data = val;
            e.at = 32'(4 * (step + 1));   // writeback of this step
            expQ.push_back(e);
            nWr++;
         end
         if (done) haltAt = 4 * (step + 1) + 1;   // state after writeback
         pc = take ? pc + 6'd1 + off[5:0] : pc + 6'd1;
      end
   endtask

   task automatic loadProgram();
      for (int a = 0; a < `IMEM_DEPTH; a++) begin
         @(posedge clk);
         #2;
         progWe = 1'b1;
         progAddr = 6'(a);
         progData = prog[a];
      end
      @(posedge clk);
      #2;
      progWe = 1'b0;
   endtask

   always @(negedge clk) begin : wbMonitor
      expWbT e;
      if (rstN && wbValid) begin
         if (expQ.size() == 0) begin
            errCount++;
            $display("register write r%0d = %h at %0t when none was expected",
                     wbRec.idx, wbRec.data, $time);
         end else begin
            e = expQ.pop_front();
            checkValue("write index", 32'(wbRec.idx), 32'(e.rec.idx));
            checkValue("write data", 32'(wbRec.data), 32'(e.rec.data));
            checkValue("write cycle after run", 32'(cycle - runCycle), e.at);
         end
      end
   end

   initial begin
      wait (cycle >= LIMIT);
      $display("timeout: core did not halt within %0d cycles", LIMIT);
      $display("Test failed");
      $finish;
   end

   initial begin
      int   expHalt;
      int   nWr;
      int   haltAt;
      int   errBefore;
      logic expErr;
      rstN = 1'b0;
      run = 1'b0;
      progWe = 1'b0;
      progAddr = '0;
      progData = '0;
      for (int i = 0; i < `REG_CNT; i++) mRegs[i] = 16'd0;   // matches reset
      repeat (8) @(posedge clk);
      #2;
      rstN = 1'b1;
      @(negedge clk);
      checkValue("wbValid after reset", 32'(wbValid), 32'd0);
      checkValue("halted after reset", 32'(halted), 32'd0);
      checkValue("err after reset", 32'(err), 32'd0);
      for (int t = 0; t < NUM_TESTS; t++) begin
         errBefore = errCount;
         buildProgram(t % 3 == 2);   // every third test carries a bad opcode
         runModel(expHalt, expErr, nWr);
         loadProgram();
         if (t == 0) begin
            checkValue("halted before run", 32'(halted), 32'd0);
            checkValue("err before run", 32'(err), 32'd0);
         end
         @(posedge clk);
         #2;
         run = 1'b1;
         runCycle = cycle;
         @(posedge clk);
         #2;
         run = 1'b0;
         @(negedge clk);
         checkValue("halted after run", 32'(halted), 32'd0);
         checkValue("err after run", 32'(err), 32'd0);
         while (!halted) @(negedge clk);
         haltAt = cycle - runCycle;
         checkValue("halt cycle after run", 32'(haltAt), 32'(expHalt));
         checkValue("err at halt", 32'(err), 32'(expErr));
         checkValue("writes still expected", 32'(expQ.size()), 32'd0);
         $display("test %0d: %0d writes, stopped by %s, %0d errors", t, nWr,
                  expErr ? "illegal opcode" : "halt", errCount - errBefore);
      end
      repeat (8) @(negedge clk);   // catch late strobes
      $display("tests %0d, errors %0d", NUM_TESTS, errCount);
      if (errCount == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
isaPkg.sv
corePkg.sv
controlUnit.sv
seqFsm.sv
pcCounter.sv
regFile.sv
aluUnit.sv
instrMem.sv
cpuTop.sv
tbCpu.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tbCpu
FILELIST  ?= tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
